// File: dv/exu_sva.sv
//--------------------------------------
// timing assertions for the execute unit
// bound into exu_top by the bind at the end
//--------------------------------------
module exu_sva #(
    parameter int XLEN = exu_pkg::XLEN_DEF
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                start_i,
    input  exu_pkg::alu_op_e    alu_op_i,
    input  logic                res_valid_o,
    input  logic                busy_o
);
    timeunit 1ns;
    timeprecision 100ps;

    import exu_pkg::*;

    logic accept;
    int   fail_cnt = 0;

    assign accept = start_i && !busy_o;

    alu_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        accept && !is_div_op(alu_op_i) |=> res_valid_o)
        else begin
            fail_cnt++;
            $error("no result pulse one cycle after an ALU issue");
        end

    // divider runs XLEN steps plus load and final register
    div_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        accept && is_div_op(alu_op_i) |-> ##(XLEN+2) res_valid_o)
        else begin
            fail_cnt++;
            $error("no result pulse XLEN+2 cycles after a divide issue");
        end

    single_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        res_valid_o |=> !res_valid_o)
        else begin
            fail_cnt++;
            $error("result pulse lasted more than one cycle");
        end

    reset_quiet: assert property (@(negedge clk)
        !rst_n_i |-> !busy_o && !res_valid_o)
        else begin
            fail_cnt++;
            $error("busy or result pulse active during reset");
        end

endmodule

bind exu_top exu_sva #(.XLEN(XLEN)) u_exu_sva (
    .clk            ( clk           ),
    .rst_n_i        ( rst_n_i       ),
    .start_i        ( start_i       ),
    .alu_op_i       ( alu_op_i      ),
    .res_valid_o    ( res_valid_o   ),
    .busy_o         ( busy_o        )
);

// File: dv/exu_tb.sv
//--------------------------------------
// testbench for the execute unit top
// random ALU, compare and divide issues checked
// against a model, plus divider corner cases
//--------------------------------------
module exu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import exu_pkg::*;

    localparam int XLEN       = exu_pkg::XLEN_DEF;
    localparam int CLK_PERIOD = 20;
    localparam int N_ALU      = 240;
    localparam int N_CMP      = 80;
    localparam int N_DIV      = 60;
    localparam int N_SPECIAL  = 8;
    localparam int N_TESTS    = N_ALU + N_CMP + N_DIV + N_SPECIAL;
    localparam int TIMEOUT_NS = N_TESTS * (XLEN + 4) * CLK_PERIOD + 1000;
    localparam int MAX_WAIT   = XLEN + 8;
    localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};
    localparam logic [XLEN-1:0] MOST_POS = {1'b0, {(XLEN-1){1'b1}}};

    logic               clk;
    logic               rst_n_i;
    logic               start_i;
    alu_op_e            alu_op_i;
    logic [XLEN-1:0]    src1_i;
    logic [XLEN-1:0]    src2_i;
    logic [XLEN-1:0]    res_o;
    logic               res_valid_o;
    logic               zero_o;
    logic               less_o;
    logic               busy_o;
    int                 value_errors;
    int                 timing_errors;

    exu_top #(.XLEN(XLEN)) UUT (
        .clk            ( clk           ),
        .rst_n_i        ( rst_n_i       ),
        .start_i        ( start_i       ),
        .alu_op_i       ( alu_op_i      ),
        .src1_i         ( src1_i        ),
        .src2_i         ( src2_i        ),
        .res_o          ( res_o         ),
        .res_valid_o    ( res_valid_o   ),
        .zero_o         ( zero_o        ),
        .less_o         ( less_o        ),
        .busy_o         ( busy_o        )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before all tests completed");
        $display("TEST FAILED");
        $finish;
    end

    //--------------------------------------
    // reference model
    //--------------------------------------
    function automatic void calc_expected(input alu_op_e op, input logic [XLEN-1:0] a,
            input logic [XLEN-1:0] b, output logic [XLEN-1:0] res,
            output logic zero, output logic less);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic signed [XLEN-1:0] quo_s;
        logic signed [XLEN-1:0] rem_s;
        int unsigned            sh;
        logic                   ovf;
        sa    = a;
        sb    = b;
        sh    = b[$clog2(XLEN)-1:0];
        ovf   = (a == MOST_NEG) && (b == '1);
        quo_s = '0;
        rem_s = '0;
        if (b != '0 && !ovf) begin
            quo_s = sa / sb;
            rem_s = sa % sb;
        end
        res  = '0;
        zero = (a == b);
        less = (sa < sb);
        case (op)
            ALU_ADD:  res = a + b;
            ALU_SUB:  res = a - b;
            ALU_AND:  res = a & b;
            ALU_OR:   res = a | b;
            ALU_XOR:  res = a ^ b;
            ALU_SLL:  res = a << sh;
            ALU_SRL:  res = a >> sh;
            ALU_SRA:  res = sa >>> sh;
            ALU_SLT:  res[0] = (sa < sb);
            ALU_SLTU: res[0] = (a < b);
            ALU_DIV:  res = (b == '0) ? '1 : (ovf ? MOST_NEG : quo_s);
            ALU_DIVU: res = (b == '0) ? '1 : a / b;
            ALU_REM:  res = (b == '0) ? a : (ovf ? '0 : rem_s);
            ALU_REMU: res = (b == '0) ? a : a % b;
            default:  res = '0;
        endcase
        // divide results carry no compare flags
        if (is_div_op(op)) begin
            zero = 1'b0;
            less = 1'b0;
        end
    endfunction

    function automatic logic [XLEN-1:0] rand_word();
        return XLEN'({$urandom, $urandom});
    endfunction

    // boundary values show up often
    function automatic logic [XLEN-1:0] pick_operand();
        case ($urandom_range(7, 0))
            0: return '0;
            1: return XLEN'(1);
            2: return '1;
            3: return MOST_NEG;
            4: return MOST_POS;
            default: return rand_word();
        endcase
    endfunction

    function automatic alu_op_e pick_op(input int first, input int last);
        return alu_op_e'($urandom_range(last, first));
    endfunction

    //--------------------------------------
    // compare tasks
    //--------------------------------------
    task automatic check_res(input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("error: res_o expected %h got %h", exp, act);
        end
    endtask

    task automatic check_flags(input logic exp_zero, input logic exp_less,
            input logic act_zero, input logic act_less);
        if (act_zero !== exp_zero) begin
            value_errors++;
            $display("error: zero_o expected %h got %h", exp_zero, act_zero);
        end
        if (act_less !== exp_less) begin
            value_errors++;
            $display("error: less_o expected %h got %h", exp_less, act_less);
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            timing_errors++;
            $display("error: %s expected %h got %h", name, exp, act);
        end
    endtask

    //--------------------------------------
    // one issue, wait for its result
    //--------------------------------------
    task automatic run_op(input alu_op_e op, input logic [XLEN-1:0] a,
            input logic [XLEN-1:0] b, input bit poke);
        logic [XLEN-1:0] exp_res;
        logic            exp_zero;
        logic            exp_less;
        int              exp_lat;
        int              cycles;
        bit              seen;
        calc_expected(op, a, b, exp_res, exp_zero, exp_less);
        exp_lat  = is_div_op(op) ? XLEN + 2 : 1;
        start_i  = 1'b1;
        alu_op_i = op;
        src1_i   = a;
        src2_i   = b;
        cycles   = 0;
        seen     = 1'b0;
        while (!seen && cycles < MAX_WAIT) begin
            @(negedge clk);
            cycles++;
            check_level("busy_o", is_div_op(op), busy_o);
            if (res_valid_o) begin
                seen = 1'b1;
                if (cycles != exp_lat) begin
                    timing_errors++;
                    $display("%s result came %0d cycles after issue instead of %0d",
                             op.name(), cycles, exp_lat);
                end
                check_res(exp_res, res_o);
                check_flags(exp_zero, exp_less, zero_o, less_o);
            end
            if (cycles == 1 || (poke && cycles == 4)) begin
                start_i = 1'b0;
            end else if (poke && cycles == 3) begin
                // second issue while the divider runs
                start_i  = 1'b1;
                alu_op_i = pick_op(0, 13);
                src1_i   = rand_word();
                src2_i   = rand_word();
            end
        end
        if (!seen) begin
            timing_errors++;
            $display("no result for %s within %0d cycles of issue", op.name(), MAX_WAIT);
        end
        @(negedge clk);
        if (res_valid_o) begin
            timing_errors++;
            $display("extra result pulse after %s", op.name());
        end
        check_level("busy_o", 1'b0, busy_o);
    endtask

    initial begin
        logic [XLEN-1:0] a;
        int              assert_errors;
        void'($urandom(32'h2599));
        rst_n_i       = 1'b0;
        start_i       = 1'b0;
        alu_op_i      = ALU_ADD;
        src1_i        = '0;
        src2_i        = '0;
        value_errors  = 0;
        timing_errors = 0;
        repeat (4) @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);
        check_level("res_valid_o", 1'b0, res_valid_o);
        check_level("busy_o", 1'b0, busy_o);
        check_res('0, res_o);

        repeat (N_ALU) run_op(pick_op(0, 7), pick_operand(), pick_operand(), 1'b0);
        repeat (N_CMP) begin
            a = pick_operand();
            run_op(pick_op(8, 9), a, ($urandom_range(3, 0) == 0) ? a : pick_operand(), 1'b0);
        end
        repeat (N_DIV) run_op(pick_op(10, 13), pick_operand(), pick_operand(), 1'b0);

        //--------------------------------------
        // divider corner cases
        //--------------------------------------
        run_op(ALU_DIV, rand_word(), '0, 1'b0);
        run_op(ALU_DIVU, rand_word(), '0, 1'b0);
        run_op(ALU_REM, rand_word(), '0, 1'b0);
        run_op(ALU_REMU, rand_word(), '0, 1'b0);
        run_op(ALU_DIV, MOST_NEG, '1, 1'b0);
        run_op(ALU_REM, MOST_NEG, '1, 1'b0);
        run_op(ALU_DIVU, rand_word(), rand_word(), 1'b1);
        run_op(ALU_REM, rand_word(), rand_word(), 1'b1);

        assert_errors = UUT.u_exu_sva.fail_cnt;
        $display("value errors: %0d, timing errors: %0d, assertion errors: %0d",
                 value_errors, timing_errors, assert_errors);
        if (value_errors + timing_errors + assert_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/alu_core.sv
//--------------------------------------
// single-cycle rv32i style ALU
// combinational result plus branch compare flags
//--------------------------------------
module alu_core #(
    parameter int XLEN = exu_pkg::XLEN_DEF
) (
    input  exu_pkg::alu_op_e    alu_op_i,
    input  logic [XLEN-1:0]     src1_i,
    input  logic [XLEN-1:0]     src2_i,
    output logic [XLEN-1:0]     res_o,
    output logic                zero_o,
    output logic                less_o
);

    import exu_pkg::*;

    localparam int SHAMT_W = $clog2(XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic [XLEN:0]      diff;
    logic               less_s;
    logic               less_u;

    assign shamt = src2_i[SHAMT_W-1:0];

    //--------------------------------------
    // shared subtractor
    //--------------------------------------
    // extra msb gives the unsigned borrow
    assign diff   = {1'b0, src1_i} - {1'b0, src2_i};
    assign less_u = diff[XLEN];

    // signs differ, the negative one is smaller
    assign less_s = (src1_i[XLEN-1] ^ src2_i[XLEN-1]) ? src1_i[XLEN-1] : diff[XLEN-1];

    assign zero_o = (diff[XLEN-1:0] == '0);
    assign less_o = less_s;

    //--------------------------------------
    // result select
    //--------------------------------------
    always_comb begin
        case (alu_op_i)
            ALU_ADD: begin
                res_o = src1_i + src2_i;
            end
            ALU_SUB: begin
                res_o = diff[XLEN-1:0];
            end
            ALU_AND: begin
                res_o = src1_i & src2_i;
            end
            ALU_OR: begin
                res_o = src1_i | src2_i;
            end
            ALU_XOR: begin
                res_o = src1_i ^ src2_i;
            end
            ALU_SLL: begin
                res_o = src1_i << shamt;
            end
            ALU_SRL: begin
                res_o = src1_i >> shamt;
            end
            ALU_SRA: begin
                res_o = XLEN'($signed(src1_i) >>> shamt);
            end
            ALU_SLT: begin
                res_o = {{(XLEN-1){1'b0}}, less_s};
            end
            ALU_SLTU: begin
                res_o = {{(XLEN-1){1'b0}}, less_u};
            end
            // divide class comes from the divider
            default: begin
                res_o = '0;
            end
        endcase
    end

endmodule

// File: verilog/div_unit.sv
//--------------------------------------
// radix-2 restoring divider, one bit per cycle
// start_i latches operands, done_o pulses with res_o
//--------------------------------------
module div_unit #(
    parameter int XLEN = exu_pkg::XLEN_DEF
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                start_i,
    input  exu_pkg::alu_op_e    op_i,
    input  logic [XLEN-1:0]     dividend_i,
    input  logic [XLEN-1:0]     divisor_i,
    output logic                busy_o,
    output logic                done_o,
    output logic [XLEN-1:0]     res_o
);

    import exu_pkg::*;

    localparam int CNT_W = $clog2(XLEN);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(XLEN - 1);

    logic               op_signed;
    logic               dvd_neg;
    logic               dvs_neg;
    logic [XLEN-1:0]    dvd_abs;
    logic [XLEN-1:0]    dvs_abs;
    logic               load;

    logic [CNT_W-1:0]   cnt_q;
    alu_op_e            op_q;
    logic               quo_neg_q;
    logic               rem_neg_q;
    logic               by_zero_q;
    logic               ovf_q;
    logic [XLEN-1:0]    dvd_raw_q;
    logic [XLEN-1:0]    dvs_q;
    logic [XLEN-1:0]    quo_q;
    logic [XLEN-1:0]    rem_q;

    logic [XLEN:0]      rem_shift;
    logic [XLEN:0]      trial;
    logic [XLEN-1:0]    rem_next;
    logic [XLEN-1:0]    quo_next;
    logic [XLEN-1:0]    quo_fix;
    logic [XLEN-1:0]    rem_fix;
    logic               rem_sel;
    logic [XLEN-1:0]    result;

    assign load      = start_i & ~busy_o;
    assign op_signed = (op_i == ALU_DIV) || (op_i == ALU_REM);
    assign dvd_neg   = op_signed & dividend_i[XLEN-1];
    assign dvs_neg   = op_signed & divisor_i[XLEN-1];
    assign dvd_abs   = dvd_neg ? -dividend_i : dividend_i;
    assign dvs_abs   = dvs_neg ? -divisor_i : divisor_i;

    // shift in next dividend bit, try subtract
    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign trial     = rem_shift - {1'b0, dvs_q};
    assign rem_next  = trial[XLEN] ? rem_shift[XLEN-1:0] : trial[XLEN-1:0];
    assign quo_next  = {quo_q[XLEN-2:0], ~trial[XLEN]};

    //--------------------------------------
    // final correction
    //--------------------------------------
    // applied to the outcome of the last step
    assign quo_fix = quo_neg_q ? -quo_next : quo_next;
    assign rem_fix = rem_neg_q ? -rem_next : rem_next;
    assign rem_sel = (op_q == ALU_REM) || (op_q == ALU_REMU);

    always_comb begin
        if (by_zero_q) begin
            result = rem_sel ? dvd_raw_q : '1;
        end else if (ovf_q) begin
            // most negative / -1
            result = rem_sel ? '0 : dvd_raw_q;
        end else begin
            result = rem_sel ? rem_fix : quo_fix;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_o <= 1'b0;
            done_o <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_o <= 1'b0;
            if (load) begin
                busy_o <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_o) begin
                if (cnt_q == LAST_STEP) begin
                    busy_o <= 1'b0;
                    done_o <= 1'b1;
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            op_q      <= op_i;
            quo_neg_q <= dvd_neg ^ dvs_neg;
            rem_neg_q <= dvd_neg;
            by_zero_q <= (divisor_i == '0);
            ovf_q     <= op_signed && (dividend_i == {1'b1, {(XLEN-1){1'b0}}})
                         && (divisor_i == '1);
            dvd_raw_q <= dividend_i;
            dvs_q     <= dvs_abs;
            quo_q     <= dvd_abs;
            rem_q     <= '0;
        end else if (busy_o) begin
            rem_q <= rem_next;
            quo_q <= quo_next;
            if (cnt_q == LAST_STEP) begin
                res_o <= result;
            end
        end
    end

endmodule

// File: verilog/exu_pkg.sv
//--------------------------------------
// shared definitions for the execute unit
// operation codes, default width and the
// divide-class check used for issue routing
//--------------------------------------
package exu_pkg;

    // default datapath width
    parameter int XLEN_DEF = 32;
    parameter int ALU_OP_W = 4;

    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        // m-extension, handled by the divider
        ALU_DIV  = 4'd10,
        ALU_DIVU = 4'd11,
        ALU_REM  = 4'd12,
        ALU_REMU = 4'd13
    } alu_op_e;

    function automatic logic is_div_op(input alu_op_e op);
        logic div_cls;
        case (op)
            ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU: div_cls = 1'b1;
            default: div_cls = 1'b0;
        endcase
        return div_cls;
    endfunction

endpackage

// File: verilog/exu_res_ctrl.sv
//--------------------------------------
// issue routing and result registers
// ALU results land next cycle, divider results on done
//--------------------------------------
module exu_res_ctrl #(
    parameter int XLEN = exu_pkg::XLEN_DEF
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                start_i,
    input  exu_pkg::alu_op_e    op_i,
    input  logic [XLEN-1:0]     alu_res_i,
    input  logic                alu_zero_i,
    input  logic                alu_less_i,
    input  logic                div_busy_i,
    input  logic                div_done_i,
    input  logic [XLEN-1:0]     div_res_i,
    output logic                div_start_o,
    output logic [XLEN-1:0]     res_o,
    output logic                zero_o,
    output logic                less_o,
    output logic                res_valid_o,
    output logic                busy_o
);

    import exu_pkg::*;

    logic accept;
    logic alu_issue;
    logic div_out_q;

    // held until the divide result has been presented
    assign busy_o = div_busy_i | div_done_i | div_out_q;

    assign accept      = start_i & ~busy_o;
    assign div_start_o = accept & is_div_op(op_i);
    assign alu_issue   = accept & ~is_div_op(op_i);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_o       <= '0;
            zero_o      <= 1'b0;
            less_o      <= 1'b0;
            res_valid_o <= 1'b0;
            div_out_q   <= 1'b0;
        end else if (alu_issue) begin
            res_o       <= alu_res_i;
            zero_o      <= alu_zero_i;
            less_o      <= alu_less_i;
            res_valid_o <= 1'b1;
            div_out_q   <= 1'b0;
        end else if (div_done_i) begin
            // no compare flags for divide results
            res_o       <= div_res_i;
            zero_o      <= 1'b0;
            less_o      <= 1'b0;
            res_valid_o <= 1'b1;
            div_out_q   <= 1'b1;
        end else begin
            res_valid_o <= 1'b0;
            div_out_q   <= 1'b0;
        end
    end

endmodule

// File: verilog/exu_top.sv
//--------------------------------------
// execute unit top, ALU and divider in parallel
// one issue at a time, busy_o blocks new issues
//--------------------------------------
module exu_top #(
    parameter int XLEN = exu_pkg::XLEN_DEF
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                start_i,
    input  exu_pkg::alu_op_e    alu_op_i,
    input  logic [XLEN-1:0]     src1_i,
    input  logic [XLEN-1:0]     src2_i,
    output logic [XLEN-1:0]     res_o,
    output logic                res_valid_o,
    output logic                zero_o,
    output logic                less_o,
    output logic                busy_o
);

    logic [XLEN-1:0]    alu_res;
    logic               alu_zero;
    logic               alu_less;
    logic               div_start;
    logic               div_busy;
    logic               div_done;
    logic [XLEN-1:0]    div_res;

    alu_core #(.XLEN(XLEN)) u_alu_core_0 (
        .alu_op_i           ( alu_op_i      ),
        .src1_i             ( src1_i        ),
        .src2_i             ( src2_i        ),
        .res_o              ( alu_res       ),
        .zero_o             ( alu_zero      ),
        .less_o             ( alu_less      )
    );

    div_unit #(.XLEN(XLEN)) u_div_unit_0 (
        .clk                ( clk           ),
        .rst_n_i            ( rst_n_i       ),
        .start_i            ( div_start     ),
        .op_i               ( alu_op_i      ),
        .dividend_i         ( src1_i        ),
        .divisor_i          ( src2_i        ),
        .busy_o             ( div_busy      ),
        .done_o             ( div_done      ),
        .res_o              ( div_res       )
    );

    exu_res_ctrl #(.XLEN(XLEN)) u_exu_res_ctrl_0 (
        .clk                ( clk           ),
        .rst_n_i            ( rst_n_i       ),
        .start_i            ( start_i       ),
        .op_i               ( alu_op_i      ),
        .alu_res_i          ( alu_res       ),
        .alu_zero_i         ( alu_zero      ),
        .alu_less_i         ( alu_less      ),
        .div_busy_i         ( div_busy      ),
        .div_done_i         ( div_done      ),
        .div_res_i          ( div_res       ),
        .div_start_o        ( div_start     ),
        .res_o              ( res_o         ),
        .zero_o             ( zero_o        ),
        .less_o             ( less_o        ),
        .res_valid_o        ( res_valid_o   ),
        .busy_o             ( busy_o        )
    );

endmodule

// File: vlog.f
verilog/exu_pkg.sv
verilog/alu_core.sv
verilog/div_unit.sv
verilog/exu_res_ctrl.sv
verilog/exu_top.sv
dv/exu_sva.sv
dv/exu_tb.sv
